// ==== design/tart_bus_pkg.sv ====
package tart_bus_pkg;

   // ----------------------------------------------------------
   // Bus widths
   // ----------------------------------------------------------
   localparam int BUS_DW = 8;                  // Data byte
   localparam int BUS_AW = 7;                  // Address from command bits 6:0

   // Request from the SPI bus master
   typedef struct packed {
      logic              cyc;                  // High for the rest of a frame
      logic              stb;                  // Held until ack
      logic              we;
      logic [BUS_AW-1:0] adr;
      logic [BUS_DW-1:0] dat;
   } bus_req_t;

   // Response from one slave, or the merged one
   typedef struct packed {
      logic              ack;                  // One-cycle pulse
      logic [BUS_DW-1:0] dat;
   } bus_rsp_t;

   // ----------------------------------------------------------
   // Address map
   // ----------------------------------------------------------
   localparam logic [3:0] AQ_BASE   = 4'h0;     // Matched against adr[6:3]
   localparam logic [4:0] CTRL_BASE = 5'h03;    // Matched against adr[6:2]

   localparam logic [BUS_AW-1:0] AQ_CTRL_ADR    = 7'h00;
   localparam logic [BUS_AW-1:0] AQ_DATA_ADR    = 7'h01;  // FIFO pop
   localparam logic [BUS_AW-1:0] AQ_COUNT_ADR   = 7'h02;
   localparam logic [BUS_AW-1:0] CTRL_RESET_ADR = 7'h0C;
   localparam logic [BUS_AW-1:0] CTRL_ERR_ADR   = 7'h0D;  // Clear on read

endpackage

// ==== design/tart_acq_pkg.sv ====
package tart_acq_pkg;

   // ----------------------------------------------------------
   // Acquisition sizes
   // ----------------------------------------------------------
   localparam int NUM_ANTENNA = 8;             // One bit per antenna, one byte per sample
   localparam int FIFO_AW     = 4;
   localparam logic [FIFO_AW:0] FIFO_DEPTH = 5'd16;  // Same width as the fill count

   // Soft reset length in b_clk cycles
   localparam logic [2:0] RESET_CYCLES = 3'd4;

   // Control register, sits in bits 4:0 of AQ_CTRL_ADR
   typedef struct packed {
      logic [2:0] delay;                       // Strobe to capture, minus one
      logic       debug;                       // Counter replaces antenna data
      logic       enable;
   } aq_ctrl_t;

   // Byte sent on MISO during every command byte
   typedef struct packed {
      logic       marker;                      // Always one, host sanity check
      logic       frame_err;
      logic       avail;                       // FIFO not empty
      logic       enable;
      logic       debug;
      logic [2:0] delay;
   } status_t;

endpackage

// ==== design/spi_slave.sv ====
`timescale 1ns/1ns

module spi_slave (
   input  logic                   b_clk,
   input  logic                   rst_i,
   input  logic                   sck_i,
   input  logic                   ssel_i,       // Active low
   input  logic                   mosi_i,
   input  tart_bus_pkg::bus_rsp_t bus_i,
   input  tart_acq_pkg::status_t  status_i,
   output logic                   miso_o,
   output tart_bus_pkg::bus_req_t bus_o,
   output logic                   frame_err_o   // Pulse on a cut-off byte
);
   import tart_bus_pkg::*;

   logic [1:0] sck_s;
   logic [1:0] ssel_s;
   logic [1:0] mosi_s;
   logic       sck_q;                           // Previous synced SCK
   logic       ssel_q;
   logic       sck_rise;
   logic       sck_fall;
   logic       ssel_fall;
   logic       ssel_rise;
   logic       active;

   logic [$clog2(BUS_DW)-1:0] bit_cnt;
   logic                      byte_done;
   logic [BUS_DW-1:0]         rx_q;
   logic [BUS_DW-1:0]         tx_q;
   logic [BUS_DW-1:0]         rd_q;             // Read data for the next byte

   logic              have_cmd;
   logic              cyc_q;
   logic              stb_q;
   logic              we_q;
   logic [BUS_AW-1:0] adr_q;
   logic [BUS_DW-1:0] dat_q;

   // ----------------------------------------------------------
   // Pin synchronizer and edge detect
   // ----------------------------------------------------------
   always_ff @(posedge b_clk) begin
      if (rst_i) begin
         sck_s  <= 2'b00;
         ssel_s <= 2'b11;                       // Deselected
         sck_q  <= 1'b0;
         ssel_q <= 1'b1;
      end else begin
         sck_s  <= {sck_s[0], sck_i};
         ssel_s <= {ssel_s[0], ssel_i};
         sck_q  <= sck_s[1];
         ssel_q <= ssel_s[1];
      end
   end

   always_ff @(posedge b_clk) begin
      mosi_s <= {mosi_s[0], mosi_i};            // Same latency as SCK
   end

   assign sck_rise  = sck_s[1] & ~sck_q;
   assign sck_fall  = ~sck_s[1] & sck_q;
   assign ssel_fall = ~ssel_s[1] & ssel_q;
   assign ssel_rise = ssel_s[1] & ~ssel_q;
   assign active    = ~ssel_s[1];

   // ----------------------------------------------------------
   // Receive side, MSB first on rising SCK
   // ----------------------------------------------------------
   always_ff @(posedge b_clk) begin
      if (rst_i) begin
         bit_cnt     <= '0;
         byte_done   <= 1'b0;
         frame_err_o <= 1'b0;
      end else begin
         byte_done   <= 1'b0;
         frame_err_o <= ssel_rise && (bit_cnt != '0);  // Frame ended mid byte
         if (ssel_fall || ssel_rise) begin
            bit_cnt <= '0;
         end else if (active && sck_rise) begin
            bit_cnt   <= bit_cnt + 1'b1;
            byte_done <= (bit_cnt == '1);       // 8th bit goes in now
         end
      end
   end

   always_ff @(posedge b_clk) begin
      if (active && sck_rise) rx_q <= {rx_q[BUS_DW-2:0], mosi_s[1]};
   end

   // Transmit side, next bit out on falling SCK
   always_ff @(posedge b_clk) begin
      if (ssel_fall) begin
         tx_q <= status_i;                      // MSB valid before first rise
      end else if (active && sck_fall) begin
         if (bit_cnt == '0)
            tx_q <= rd_q;                       // Byte boundary
         else
            tx_q <= {tx_q[BUS_DW-2:0], 1'b0};
      end
   end

   assign miso_o = active & tx_q[BUS_DW-1];

   // ----------------------------------------------------------
   // Frame sequencer and bus master
   // ----------------------------------------------------------
   always_ff @(posedge b_clk) begin
      if (rst_i) begin
         have_cmd <= 1'b0;
         cyc_q    <= 1'b0;
         stb_q    <= 1'b0;
      end else if (ssel_rise) begin
         have_cmd <= 1'b0;                      // Frame over
         cyc_q    <= 1'b0;
         stb_q    <= 1'b0;
      end else begin
         if (stb_q && bus_i.ack) stb_q <= 1'b0;
         if (byte_done) begin
            if (!have_cmd) begin
               have_cmd <= 1'b1;
               stb_q    <= ~rx_q[BUS_DW-1];      // Read frames fetch right away
               cyc_q    <= cyc_q | ~rx_q[BUS_DW-1];
            end else begin
               stb_q <= 1'b1;                   // One transfer per data byte
               cyc_q <= 1'b1;
            end
         end
      end
   end

   // Command fields and write data, held while stb is high
   always_ff @(posedge b_clk) begin
      if (byte_done && !have_cmd) begin
         we_q  <= rx_q[BUS_DW-1];
         adr_q <= rx_q[BUS_AW-1:0];
      end
      if (byte_done && have_cmd) dat_q <= rx_q;
      if (ssel_fall)
         rd_q <= '0;                            // Write frames shift out zeros
      else if (stb_q && bus_i.ack && !we_q)
         rd_q <= bus_i.dat;
   end

   assign bus_o = '{cyc: cyc_q, stb: stb_q, we: we_q, adr: adr_q, dat: dat_q};

endmodule

// ==== design/tart_control.sv ====
`timescale 1ns/1ns

module tart_control (
   input  logic                   b_clk,
   input  logic                   rst_i,
   input  logic                   stb_i,        // Already decoded
   input  tart_bus_pkg::bus_req_t req_i,
   input  logic                   frame_err_i,
   output tart_bus_pkg::bus_rsp_t rsp_o,
   output logic                   soft_rst_o,
   output logic                   frame_err_o
);
   import tart_bus_pkg::*;
   import tart_acq_pkg::*;

   logic                            ack_q;
   logic [BUS_DW-1:0]               dat_q;
   logic [$bits(RESET_CYCLES)-1:0]  rst_cnt;    // Cycles of soft reset left
   logic                            err_q;
   logic                            access;
   logic                            rst_wr;
   logic                            err_rd;

   // One access per strobe, ack a cycle later
   assign access = stb_i && !ack_q;
   assign rst_wr = access && req_i.we && (req_i.adr == CTRL_RESET_ADR) && req_i.dat[0];
   assign err_rd = access && !req_i.we && (req_i.adr == CTRL_ERR_ADR);

   // ----------------------------------------------------------
   // Soft reset counter and sticky error flag
   // ----------------------------------------------------------
   always_ff @(posedge b_clk) begin
      if (rst_i) begin
         ack_q   <= 1'b0;
         rst_cnt <= '0;
         err_q   <= 1'b0;
      end else begin
         ack_q <= access;
         if (rst_wr)
            rst_cnt <= RESET_CYCLES;
         else if (rst_cnt != '0)
            rst_cnt <= rst_cnt - 1'b1;
         if (frame_err_i)
            err_q <= 1'b1;                      // New error wins over the clear
         else if (err_rd)
            err_q <= 1'b0;
      end
   end

   // Read data, reset register reads as zero
   always_ff @(posedge b_clk) begin
      if (access) dat_q <= err_rd ? {{(BUS_DW-1){1'b0}}, err_q} : '0;
   end

   assign rsp_o       = '{ack: ack_q, dat: dat_q};
   assign soft_rst_o  = (rst_cnt != '0);
   assign frame_err_o = err_q;

endmodule

// ==== design/tart_acquire.sv ====
`timescale 1ns/1ns

module tart_acquire (
   input  logic                                 b_clk,
   input  logic                                 rst_i,    // Includes soft reset
   input  logic                                 stb_i,
   input  tart_bus_pkg::bus_req_t               req_i,
   input  logic                                 ax_stb_i,
   input  logic [tart_acq_pkg::NUM_ANTENNA-1:0] ax_data_i,
   output tart_bus_pkg::bus_rsp_t               rsp_o,
   output tart_acq_pkg::aq_ctrl_t               ctrl_o,
   output logic                                 avail_o
);
   import tart_bus_pkg::*;
   import tart_acq_pkg::*;

   aq_ctrl_t          ctrl_q;
   logic              ack_q;
   logic [BUS_DW-1:0] dat_q;
   logic              access;

   logic [7:0]             stb_dly;             // One tap per delay setting
   logic                   capture;
   logic [NUM_ANTENNA-1:0] dbg_cnt;
   logic [NUM_ANTENNA-1:0] sample;

   logic [NUM_ANTENNA-1:0] fifo_mem [FIFO_DEPTH];
   logic [FIFO_AW-1:0]     wr_ptr;
   logic [FIFO_AW-1:0]     rd_ptr;
   logic [FIFO_AW:0]       count;
   logic                   full;
   logic                   push;
   logic                   pop;

   assign access = stb_i && !ack_q;

   // ----------------------------------------------------------
   // Control register and bus response
   // ----------------------------------------------------------
   always_ff @(posedge b_clk) begin
      if (rst_i) begin
         ack_q  <= 1'b0;
         ctrl_q <= '0;
      end else begin
         ack_q <= access;
         if (access && req_i.we && (req_i.adr == AQ_CTRL_ADR))
            ctrl_q <= aq_ctrl_t'(req_i.dat[$bits(aq_ctrl_t)-1:0]);
      end
   end

   always_ff @(posedge b_clk) begin
      if (access) begin
         case (req_i.adr)
            AQ_CTRL_ADR:  dat_q <= {{(BUS_DW-$bits(aq_ctrl_t)){1'b0}}, ctrl_q};
            AQ_DATA_ADR:  dat_q <= pop ? fifo_mem[rd_ptr] : '0;  // Zero when empty
            AQ_COUNT_ADR: dat_q <= {{(BUS_DW-FIFO_AW-1){1'b0}}, count};
            default:      dat_q <= '0;           // Spare slots in the block
         endcase
      end
   end

   // ----------------------------------------------------------
   // Delayed capture
   // ----------------------------------------------------------
   always_ff @(posedge b_clk) begin
      if (rst_i) begin
         stb_dly <= '0;
         dbg_cnt <= '0;
      end else begin
         stb_dly <= {stb_dly[6:0], ax_stb_i};
         if (capture) dbg_cnt <= dbg_cnt + 1'b1;  // Counts every capture
      end
   end

   // Tap 0 already gives one cycle of delay
   assign capture = ctrl_q.enable && stb_dly[ctrl_q.delay];
   assign sample  = ctrl_q.debug ? dbg_cnt : ax_data_i;

   // ----------------------------------------------------------
   // Readback FIFO
   // ----------------------------------------------------------
   assign full = (count == FIFO_DEPTH);
   assign push = capture && !full;               // Drop when full
   assign pop  = access && !req_i.we && (req_i.adr == AQ_DATA_ADR) && (count != '0);

   always_ff @(posedge b_clk) begin
      if (push) fifo_mem[wr_ptr] <= sample;
   end

   always_ff @(posedge b_clk) begin
      if (rst_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) wr_ptr <= wr_ptr + 1'b1;
         if (pop) rd_ptr <= rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;             // Both or neither
         endcase
      end
   end

   assign rsp_o   = '{ack: ack_q, dat: dat_q};
   assign ctrl_o  = ctrl_q;
   assign avail_o = (count != '0);

endmodule

// ==== design/tart_top.sv ====
`timescale 1ns/1ns

module tart_top (
   input  logic                                 b_clk,
   input  logic                                 rst_i,
   input  logic                                 spi_sck_i,
   input  logic                                 spi_ssel_i,
   input  logic                                 spi_mosi_i,
   input  logic                                 ax_stb_i,
   input  logic [tart_acq_pkg::NUM_ANTENNA-1:0] ax_data_i,
   output logic                                 spi_miso_o,
   output logic                                 led_o
);
   import tart_bus_pkg::*;
   import tart_acq_pkg::*;

   bus_req_t b_req;
   bus_rsp_t b_rsp;
   bus_rsp_t a_rsp;                             // Acquire unit
   bus_rsp_t c_rsp;                             // Control unit
   aq_ctrl_t aq_ctrl;
   status_t  status;

   logic a_hit, c_hit;
   logic a_stb, c_stb, u_stb;
   logic a_sel, c_sel;
   logic u_ack;                                 // Unmapped address ack
   logic soft_rst, aq_rst;
   logic aq_avail, spi_ferr, err_flag;

   // ----------------------------------------------------------
   // Address decode
   // ----------------------------------------------------------
   assign a_hit = (b_req.adr[BUS_AW-1:3] == AQ_BASE);
   assign c_hit = (b_req.adr[BUS_AW-1:2] == CTRL_BASE);
   assign a_stb = b_req.stb && a_hit;
   assign c_stb = b_req.stb && c_hit;
   assign u_stb = b_req.stb && !a_hit && !c_hit;

   // Hold the selected slave until it acks
   always_ff @(posedge b_clk) begin
      if (rst_i || !b_req.cyc) begin
         a_sel <= 1'b0;
         c_sel <= 1'b0;
         u_ack <= 1'b0;
      end else begin
         a_sel <= (a_sel | a_stb) & ~a_rsp.ack;
         c_sel <= (c_sel | c_stb) & ~c_rsp.ack;
         u_ack <= u_stb & ~u_ack;               // Nobody home, ack with zero
      end
   end

   assign b_rsp.ack = a_rsp.ack | c_rsp.ack | u_ack;
   assign b_rsp.dat = (c_stb || c_sel) ? c_rsp.dat :
                      (a_stb || a_sel) ? a_rsp.dat : '0;

   // Status byte for the command slot
   assign status = '{marker: 1'b1, frame_err: err_flag, avail: aq_avail,
                     enable: aq_ctrl.enable, debug: aq_ctrl.debug, delay: aq_ctrl.delay};

   assign aq_rst = rst_i | soft_rst;
   assign led_o  = aq_ctrl.enable;

   // ----------------------------------------------------------
   // Units
   // ----------------------------------------------------------
   spi_slave i_spi (
      .b_clk      (b_clk),
      .rst_i      (rst_i),
      .sck_i      (spi_sck_i),
      .ssel_i     (spi_ssel_i),
      .mosi_i     (spi_mosi_i),
      .bus_i      (b_rsp),
      .status_i   (status),
      .miso_o     (spi_miso_o),
      .bus_o      (b_req),
      .frame_err_o(spi_ferr)
   );

   tart_control i_ctrl (
      .b_clk      (b_clk),
      .rst_i      (rst_i),
      .stb_i      (c_stb),
      .req_i      (b_req),
      .frame_err_i(spi_ferr),
      .rsp_o      (c_rsp),
      .soft_rst_o (soft_rst),
      .frame_err_o(err_flag)
   );

   tart_acquire i_acq (
      .b_clk    (b_clk),
      .rst_i    (aq_rst),
      .stb_i    (a_stb),
      .req_i    (b_req),
      .ax_stb_i (ax_stb_i),
      .ax_data_i(ax_data_i),
      .rsp_o    (a_rsp),
      .ctrl_o   (aq_ctrl),
      .avail_o  (aq_avail)
   );

endmodule

// ==== tb/spi_host.sv ====
`timescale 1ns/1ns

module spi_host #(
   parameter int HALF_CYCLES = 8               // b_clk cycles per SCK half period
) (
   input  logic b_clk,
   input  logic miso_i,
   output logic sck_o,
   output logic ssel_o,                        // Active low
   output logic mosi_o
);

   // Idle bus, mode 0
   initial begin
      sck_o  = 1'b0;
      ssel_o = 1'b1;
      mosi_o = 1'b0;
   end

   // Step n edges, land 1 ns past the last one
   task automatic wait_cycles(input int n);
      repeat (n) @(posedge b_clk);
      #1;
   endtask

   // ----------------------------------------------------------
   // Bit and byte level
   // ----------------------------------------------------------
   task automatic shift_bit(input logic out_bit, output logic in_bit);
      mosi_o = out_bit;                        // Set up while SCK is low
      wait_cycles(HALF_CYCLES);
      in_bit = miso_i;                         // Settled since the last fall
      sck_o  = 1'b1;
      wait_cycles(HALF_CYCLES);
      sck_o  = 1'b0;
   endtask

   task automatic xfer_byte(input logic [7:0] tx, output logic [7:0] rx);
      logic in_bit;
      for (int i = 7; i >= 0; i--) begin
         shift_bit(tx[i], in_bit);             // MSB first
         rx[i] = in_bit;
      end
   endtask

   // ----------------------------------------------------------
   // Frame level
   // ----------------------------------------------------------
   task automatic begin_frame();
      mosi_o = 1'b0;
      ssel_o = 1'b0;                           // First bit waits a half period
   endtask

   task automatic end_frame();
      wait_cycles(HALF_CYCLES);
      ssel_o = 1'b1;
      mosi_o = 1'b0;
      wait_cycles(2 * HALF_CYCLES);            // Gap before the next frame
   endtask

   // Frame dropped mid byte
   task automatic cut_frame(input int nbits);
      logic in_bit;
      begin_frame();
      for (int i = 0; i < nbits; i++) begin
         shift_bit(1'b1, in_bit);
      end
      end_frame();
   endtask

endmodule

// ==== tb/tart_tb.sv ====
`timescale 1ns/1ns

module tart_tb;
   import tart_bus_pkg::*;

   // ----------------------------------------------------------
   // Run length and timeout
   // ----------------------------------------------------------
   localparam int HALF_CYCLES    = 8;
   localparam int BYTE_CYCLES    = 16 * HALF_CYCLES;
   localparam int FRAME_CYCLES   = 4 * HALF_CYCLES;  // Select and idle gap
   localparam int STROBE_CYCLES  = 10;               // Covers the longest delay
   localparam int MAX_BYTES      = 80;
   localparam int MAX_FRAMES     = 30;
   localparam int MAX_STROBES    = 40;
   localparam int TIMEOUT_CYCLES = 2 * (MAX_BYTES * BYTE_CYCLES + MAX_FRAMES * FRAME_CYCLES
                                        + MAX_STROBES * STROBE_CYCLES + 10);
   localparam logic [6:0] UNMAPPED_ADR = 7'h40;

   logic       b_clk;
   logic       rst_i;
   logic       sck;
   logic       ssel;
   logic       mosi;
   logic       miso;
   logic       ax_stb;
   logic [7:0] ax_data;
   logic       led;
   int         cycle_cnt;
   logic [4:0] ctrl_val;
   logic [2:0] dly;

   // Expected state
   logic [7:0] exp_fifo[$];
   logic [4:0] exp_ctrl;                        // Delay, debug, enable
   logic [7:0] exp_dbg;
   logic       exp_err;

   // Reads waiting for the checker
   logic [7:0] got_q[$];
   logic [7:0] want_q[$];
   string      what_q[$];

   initial b_clk = 1'b0;
   always #2 b_clk = ~b_clk;

   tart_top i_dut (
      .b_clk     (b_clk),
      .rst_i     (rst_i),
      .spi_sck_i (sck),
      .spi_ssel_i(ssel),
      .spi_mosi_i(mosi),
      .ax_stb_i  (ax_stb),
      .ax_data_i (ax_data),
      .spi_miso_o(miso),
      .led_o     (led)
   );

   spi_host #(.HALF_CYCLES(HALF_CYCLES)) i_host (
      .b_clk (b_clk),
      .miso_i(miso),
      .sck_o (sck),
      .ssel_o(ssel),
      .mosi_o(mosi)
   );

   // ----------------------------------------------------------
   // Reference model
   // ----------------------------------------------------------
   function automatic logic [7:0] predict_read(input logic [6:0] adr);
      logic [7:0] val;
      val = 8'h00;
      case (adr)
         AQ_CTRL_ADR:  val = {3'b000, exp_ctrl};
         AQ_DATA_ADR:  if (exp_fifo.size() > 0) val = exp_fifo.pop_front();
         AQ_COUNT_ADR: val = 8'(exp_fifo.size());
         CTRL_ERR_ADR: begin
            val     = {7'b0, exp_err};
            exp_err = 1'b0;                     // Cleared by the read
         end
         default:      val = 8'h00;             // Reset register, spares, unmapped
      endcase
      return val;
   endfunction

   function automatic void apply_write(input logic [6:0] adr, input logic [7:0] dat);
      if (adr == AQ_CTRL_ADR) exp_ctrl = dat[4:0];
      if (adr == CTRL_RESET_ADR && dat[0]) begin
         exp_fifo.delete();
         exp_ctrl = '0;
         exp_dbg  = '0;
      end
   endfunction

   // Marker, error, available, enable, debug, delay
   function automatic logic [7:0] expected_status();
      return {1'b1, exp_err, exp_fifo.size() != 0, exp_ctrl[0], exp_ctrl[1], exp_ctrl[4:2]};
   endfunction

   // ----------------------------------------------------------
   // Checking
   // ----------------------------------------------------------
   task automatic check_equal(input logic [7:0] got, input logic [7:0] want,
                              input string what);
      if (got !== want) begin
         $display("error at %0t ns: %s read %02h, expected %02h", $time, what, got, want);
         $display("*** TEST FAILED ***");
         $fatal(1, "data mismatch");
      end
   endtask

   task automatic expect_byte(input logic [7:0] got, input logic [7:0] want,
                              input string what);
      got_q.push_back(got);
      want_q.push_back(want);
      what_q.push_back(what);
   endtask

   always @(posedge b_clk) begin
      while (got_q.size() > 0) begin
         check_equal(got_q.pop_front(), want_q.pop_front(), what_q.pop_front());
      end
   end

   always @(posedge b_clk) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("timeout: test still running after %0d cycles", TIMEOUT_CYCLES);
         $display("*** TEST FAILED ***");
         $fatal(1, "timeout");
      end
   end

   // ----------------------------------------------------------
   // Stimulus tasks
   // ----------------------------------------------------------
   task automatic wait_cycles(input int n);
      repeat (n) @(posedge b_clk);
      #1;
   endtask

   task automatic write_reg(input logic [6:0] adr, input logic [7:0] dat);
      logic [7:0] rx;
      logic [7:0] want;
      want = expected_status();
      i_host.begin_frame();
      i_host.xfer_byte({1'b1, adr}, rx);
      expect_byte(rx, want, "status byte");
      i_host.xfer_byte(dat, rx);
      i_host.end_frame();
      apply_write(adr, dat);
      expect_byte({7'b0, led}, {7'b0, exp_ctrl[0]}, "led_o");
   endtask

   // Every byte of a read frame triggers the next fetch
   task automatic read_regs(input logic [6:0] adr, input int n, input string what);
      logic [7:0] rx;
      logic [7:0] want;
      want = expected_status();
      i_host.begin_frame();
      i_host.xfer_byte({1'b0, adr}, rx);
      expect_byte(rx, want, "status byte");
      for (int i = 0; i < n; i++) begin
         want = predict_read(adr);
         i_host.xfer_byte(8'h00, rx);
         expect_byte(rx, want, what);
      end
      i_host.end_frame();
      void'(predict_read(adr));                 // Last fetch never shifted out
   endtask

   task automatic pulse_strobe(input logic [7:0] data);
      ax_data = data;                           // Held until the next strobe
      ax_stb  = 1'b1;
      wait_cycles(1);
      ax_stb = 1'b0;
      wait_cycles(STROBE_CYCLES - 1);
      if (exp_ctrl[0]) begin
         if (exp_fifo.size() < 16) exp_fifo.push_back(exp_ctrl[1] ? exp_dbg : data);
         exp_dbg = exp_dbg + 8'd1;              // Counts drops as well
      end
   endtask

   // ----------------------------------------------------------
   // Test sequence
   // ----------------------------------------------------------
   initial begin
      void'($urandom(32'h888fafc7));
      rst_i     = 1'b1;
      ax_stb    = 1'b0;
      ax_data   = 8'h00;
      cycle_cnt = 0;
      exp_ctrl  = '0;
      exp_dbg   = '0;
      exp_err   = 1'b0;
      wait_cycles(10);
      rst_i = 1'b0;
      wait_cycles(4);

      // Idle status and unmapped read
      expect_byte({7'b0, led}, 8'h00, "led_o after reset");
      read_regs(UNMAPPED_ADR, 1, "unmapped address");

      // Control register round trip
      repeat (3) begin
         ctrl_val = 5'($urandom());
         write_reg(AQ_CTRL_ADR, {3'b000, ctrl_val});
         read_regs(AQ_CTRL_ADR, 1, "control register");
      end

      // Debug counter capture
      dly = 3'($urandom());
      write_reg(AQ_CTRL_ADR, {3'b000, dly, 2'b11});
      repeat (6) pulse_strobe(8'($urandom()));
      read_regs(AQ_COUNT_ADR, 1, "FIFO count");
      read_regs(AQ_DATA_ADR, 6, "debug sample");
      read_regs(AQ_DATA_ADR, 1, "empty FIFO");

      // Antenna capture that overfills by four
      dly = 3'($urandom());
      write_reg(AQ_CTRL_ADR, {3'b000, dly, 2'b01});
      repeat (20) pulse_strobe(8'($urandom()));
      read_regs(AQ_COUNT_ADR, 1, "FIFO count");
      read_regs(AQ_DATA_ADR, 16, "antenna sample");
      read_regs(AQ_COUNT_ADR, 1, "FIFO count after drain");

      // Soft reset
      dly = 3'($urandom());
      write_reg(AQ_CTRL_ADR, {3'b000, dly, 2'b11});
      repeat (3) pulse_strobe(8'($urandom()));
      write_reg(CTRL_RESET_ADR, 8'h01);
      read_regs(AQ_COUNT_ADR, 1, "FIFO count after soft reset");
      read_regs(AQ_CTRL_ADR, 1, "control after soft reset");
      write_reg(AQ_CTRL_ADR, 8'h03);
      repeat (2) pulse_strobe(8'($urandom()));
      read_regs(AQ_DATA_ADR, 2, "debug sample after soft reset");

      // Framing error stays until read
      i_host.cut_frame(5);
      exp_err = 1'b1;
      read_regs(CTRL_ERR_ADR, 1, "frame error flag");
      read_regs(CTRL_ERR_ADR, 1, "frame error after clear");

      while (got_q.size() > 0) wait_cycles(1);
      wait_cycles(1);
      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule

// ==== build.f ====
design/tart_bus_pkg.sv
design/tart_acq_pkg.sv
design/spi_slave.sv
design/tart_control.sv
design/tart_acquire.sv
design/tart_top.sv
tb/spi_host.sv
tb/tart_tb.sv

// ==== Makefile ====
# Verilator build and run of the TART host-access testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --timescale 1ns/1ns -Wno-fatal \
		-f build.f --top-module tart_tb --Mdir obj_dir -o tart_sim
	./obj_dir/tart_sim 2>&1 | tee $(LOG)
	@grep -qF '*** TEST PASSED ***' $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)
